// ==== common/bubble_prof_macros.svh ====
`ifndef BUBBLE_PROF_MACROS_SVH
`define BUBBLE_PROF_MACROS_SVH

// Program counter width.
`define BP_PC_WIDTH 32

// Integer register file.
`define BP_REG_ADDR_WIDTH 5
`define BP_REG_ELS 32

// Bubble statistics.
`define BP_CTR_WIDTH 32
`define BP_NUM_TYPES 9

// Readout select, wide enough for every bubble type.
`define BP_SEL_WIDTH 4

`endif

// ==== common/bubble_prof_pkg.sv ====
`default_nettype none

package bubble_prof_pkg;

  // ------------------------------------------------------------------------
  // EXE bubble causes
  // ------------------------------------------------------------------------

  // The value of each entry is also the index of its counter.
  typedef enum logic [3:0] {
    e_no_bubble          = 4'd0,
    e_branch_miss        = 4'd1,
    e_jalr_miss          = 4'd2,
    e_icache_miss        = 4'd3,
    e_depend_remote_load = 4'd4,
    e_depend_idiv        = 4'd5,
    e_stall_bypass       = 4'd6,
    e_stall_fence        = 4'd7,
    e_stall_remote_req   = 4'd8
  } bubble_type_e;

  // ------------------------------------------------------------------------
  // Scoreboard
  // ------------------------------------------------------------------------

  // Long operation that holds a destination register.
  typedef enum logic {
    e_sb_remote_load = 1'b0,
    e_sb_idiv        = 1'b1
  } sb_kind_e;

endpackage

`default_nettype wire

// ==== design/scoreboard_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module scoreboard_tracker (
  input  wire                           clk_i,
  input  wire                           reset_i,

  input  wire                           set_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]  set_id_i,
  input  var  bubble_prof_pkg::sb_kind_e set_kind_i,

  input  wire                           clear_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]  clear_id_i,

  output logic [`BP_REG_ELS-1:0]        pending_remote_load_o,
  output logic [`BP_REG_ELS-1:0]        pending_idiv_o
);

  logic [`BP_REG_ELS-1:0] remote_load_r;
  logic [`BP_REG_ELS-1:0] idiv_r;

  // x0 is hardwired, so it never waits on anything.
  wire set_valid = set_i & (set_id_i != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      remote_load_r <= '0;
      idiv_r <= '0;
    end else begin
      if (clear_i) begin
        remote_load_r[clear_id_i] <= 1'b0;
        idiv_r[clear_id_i] <= 1'b0;
      end
      // Placed after the clear so a set to the same register wins.
      if (set_valid) begin
        remote_load_r[set_id_i] <= (set_kind_i == bubble_prof_pkg::e_sb_remote_load);
        idiv_r[set_id_i] <= (set_kind_i == bubble_prof_pkg::e_sb_idiv);
      end
    end
  end

  assign pending_remote_load_o = remote_load_r;
  assign pending_idiv_o = idiv_r;

  // A writeback only retires a register that an earlier issue marked.
  clear_has_pending: assert property (
    @(posedge clk_i) disable iff (reset_i)
    clear_i |-> (remote_load_r[clear_id_i] | idiv_r[clear_id_i])
  );

  x0_never_pending: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !remote_load_r[0] && !idiv_r[0]
  );

endmodule

`default_nettype wire

// ==== bubble_classifier/exe_bubble_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module exe_bubble_classifier (
  input  wire                            clk_i,
  input  wire                            reset_i,

  input  wire [`BP_PC_WIDTH-1:0]         if_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]         id_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]         exe_pc_i,

  input  wire                            stall_all_i,
  input  wire                            branch_mispredict_i,
  input  wire                            jalr_mispredict_i,
  input  wire                            icache_miss_i,
  input  wire                            icache_miss_in_pipe_i,

  input  wire                            stall_depend_long_op_i,
  input  wire                            stall_bypass_i,
  input  wire                            stall_fence_i,
  input  wire                            stall_remote_req_i,

  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rs1_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rs2_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rd_i,
  input  wire                            id_read_rs1_i,
  input  wire                            id_read_rs2_i,
  input  wire                            id_write_rd_i,

  input  wire [`BP_REG_ELS-1:0]          pending_remote_load_i,
  input  wire [`BP_REG_ELS-1:0]          pending_idiv_i,

  output bubble_prof_pkg::bubble_type_e  exe_bubble_type_o,
  output logic [`BP_PC_WIDTH-1:0]        exe_bubble_pc_o
);

  // True when any register the ID instruction touches is flagged.
  function automatic logic operand_pending(
    input logic [`BP_REG_ELS-1:0]        pending,
    input logic [`BP_REG_ADDR_WIDTH-1:0] rs1,
    input logic [`BP_REG_ADDR_WIDTH-1:0] rs2,
    input logic [`BP_REG_ADDR_WIDTH-1:0] rd,
    input logic                          read_rs1,
    input logic                          read_rs2,
    input logic                          write_rd
  );
    operand_pending = (read_rs1 & pending[rs1])
                    | (read_rs2 & pending[rs2])
                    | (write_rd & pending[rd]);
  endfunction

  // --------------------------------------------------------------------------
  // Fetch side
  // --------------------------------------------------------------------------

  // PC of the most recent instruction cache miss.
  logic [`BP_PC_WIDTH-1:0] icache_miss_pc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      icache_miss_pc_r <= '0;
    end else if (icache_miss_i) begin
      icache_miss_pc_r <= if_pc_i;
    end
  end

  // Bubble sitting in ID, one stage ahead of EXE.
  bubble_prof_pkg::bubble_type_e id_bubble_r;
  logic [`BP_PC_WIDTH-1:0]       id_bubble_pc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_bubble_r <= bubble_prof_pkg::e_no_bubble;
      id_bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      if (branch_mispredict_i) begin
        id_bubble_r <= bubble_prof_pkg::e_branch_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (jalr_mispredict_i) begin
        id_bubble_r <= bubble_prof_pkg::e_jalr_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (icache_miss_in_pipe_i) begin
        id_bubble_r <= bubble_prof_pkg::e_icache_miss;
        id_bubble_pc_r <= icache_miss_pc_r;
      end else begin
        id_bubble_r <= bubble_prof_pkg::e_no_bubble;
        id_bubble_pc_r <= '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // EXE classification
  // --------------------------------------------------------------------------

  logic depend_remote_load;
  logic depend_idiv;

  assign depend_remote_load = stall_depend_long_op_i
    & operand_pending(pending_remote_load_i, id_rs1_i, id_rs2_i, id_rd_i,
                      id_read_rs1_i, id_read_rs2_i, id_write_rd_i);
  assign depend_idiv = stall_depend_long_op_i
    & operand_pending(pending_idiv_i, id_rs1_i, id_rs2_i, id_rd_i,
                      id_read_rs1_i, id_read_rs2_i, id_write_rd_i);

  bubble_prof_pkg::bubble_type_e exe_bubble_n;
  logic [`BP_PC_WIDTH-1:0]       exe_bubble_pc_n;

  // First match wins.
  always_comb begin
    exe_bubble_n = bubble_prof_pkg::e_no_bubble;
    exe_bubble_pc_n = '0;
    if (branch_mispredict_i) begin
      exe_bubble_n = bubble_prof_pkg::e_branch_miss;
      exe_bubble_pc_n = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      exe_bubble_n = bubble_prof_pkg::e_jalr_miss;
      exe_bubble_pc_n = exe_pc_i;
    end else if (id_bubble_r != bubble_prof_pkg::e_no_bubble) begin
      exe_bubble_n = id_bubble_r;
      exe_bubble_pc_n = id_bubble_pc_r;
    end else if (depend_remote_load) begin
      exe_bubble_n = bubble_prof_pkg::e_depend_remote_load;
      exe_bubble_pc_n = id_pc_i;
    end else if (depend_idiv) begin
      exe_bubble_n = bubble_prof_pkg::e_depend_idiv;
      exe_bubble_pc_n = id_pc_i;
    end else if (stall_bypass_i) begin
      exe_bubble_n = bubble_prof_pkg::e_stall_bypass;
      exe_bubble_pc_n = id_pc_i;
    end else if (stall_fence_i) begin
      exe_bubble_n = bubble_prof_pkg::e_stall_fence;
      exe_bubble_pc_n = id_pc_i;
    end else if (stall_remote_req_i) begin
      exe_bubble_n = bubble_prof_pkg::e_stall_remote_req;
      exe_bubble_pc_n = id_pc_i;
    end
  end

  bubble_prof_pkg::bubble_type_e exe_bubble_r;
  logic [`BP_PC_WIDTH-1:0]       exe_bubble_pc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_bubble_r <= bubble_prof_pkg::e_no_bubble;
      exe_bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      exe_bubble_r <= exe_bubble_n;
      exe_bubble_pc_r <= exe_bubble_pc_n;
    end
  end

  assign exe_bubble_type_o = exe_bubble_r;
  assign exe_bubble_pc_o = exe_bubble_pc_r;

  // EXE resolves one control transfer at a time.
  one_mispredict: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(branch_mispredict_i && jalr_mispredict_i)
  );

endmodule

`default_nettype wire

// ==== design/bubble_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module bubble_counter #(
  parameter int unsigned type_index_p = 0
) (
  input  wire                            clk_i,
  input  wire                            reset_i,

  input  var  bubble_prof_pkg::bubble_type_e bubble_type_i,
  input  wire [`BP_PC_WIDTH-1:0]         bubble_pc_i,

  output logic [`BP_CTR_WIDTH-1:0]       count_o,
  output logic [`BP_PC_WIDTH-1:0]        last_pc_o
);

  logic hit;
  logic [`BP_CTR_WIDTH-1:0] count_r;
  logic [`BP_PC_WIDTH-1:0]  last_pc_r;

  assign hit = (bubble_type_i == bubble_prof_pkg::bubble_type_e'(type_index_p));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
      last_pc_r <= '0;
    end else if (hit) begin
      count_r <= count_r + 1'b1;
      last_pc_r <= bubble_pc_i;
    end
  end

  assign count_o = count_r;
  assign last_pc_o = last_pc_r;

  // Saturation is not handled, so the run must stay short of it.
  count_no_wrap: assert property (
    @(posedge clk_i) disable iff (reset_i)
    hit |-> (count_r != '1)
  );

endmodule

`default_nettype wire

// ==== design/bubble_stat_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module bubble_stat_readout (
  input  wire                                        clk_i,
  input  wire                                        reset_i,

  input  wire [`BP_SEL_WIDTH-1:0]                    sel_i,
  input  wire [`BP_NUM_TYPES-1:0][`BP_CTR_WIDTH-1:0] counts_i,
  input  wire [`BP_NUM_TYPES-1:0][`BP_PC_WIDTH-1:0]  last_pcs_i,

  output logic [`BP_CTR_WIDTH-1:0]                   count_o,
  output logic [`BP_PC_WIDTH-1:0]                    last_pc_o
);

  logic sel_in_range;
  logic [`BP_CTR_WIDTH-1:0] count_r;
  logic [`BP_PC_WIDTH-1:0]  last_pc_r;

  assign sel_in_range = (sel_i < `BP_NUM_TYPES);

  // Out of range selects read back as zero.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
      last_pc_r <= '0;
    end else if (sel_in_range) begin
      count_r <= counts_i[sel_i];
      last_pc_r <= last_pcs_i[sel_i];
    end else begin
      count_r <= '0;
      last_pc_r <= '0;
    end
  end

  assign count_o = count_r;
  assign last_pc_o = last_pc_r;

  sel_valid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    sel_in_range
  );

endmodule

`default_nettype wire

// ==== design/bubble_profiler_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module bubble_profiler_top (
  input  wire                            clk_i,
  input  wire                            reset_i,

  input  wire [`BP_PC_WIDTH-1:0]         if_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]         id_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]         exe_pc_i,

  input  wire                            stall_all_i,
  input  wire                            branch_mispredict_i,
  input  wire                            jalr_mispredict_i,
  input  wire                            icache_miss_i,
  input  wire                            icache_miss_in_pipe_i,

  input  wire                            stall_depend_long_op_i,
  input  wire                            stall_bypass_i,
  input  wire                            stall_fence_i,
  input  wire                            stall_remote_req_i,

  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rs1_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rs2_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   id_rd_i,
  input  wire                            id_read_rs1_i,
  input  wire                            id_read_rs2_i,
  input  wire                            id_write_rd_i,

  input  wire                            sb_set_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   sb_set_id_i,
  input  var  bubble_prof_pkg::sb_kind_e sb_set_kind_i,
  input  wire                            sb_clear_i,
  input  wire [`BP_REG_ADDR_WIDTH-1:0]   sb_clear_id_i,

  input  wire [`BP_SEL_WIDTH-1:0]        stat_sel_i,

  output bubble_prof_pkg::bubble_type_e  exe_bubble_type_o,
  output logic [`BP_PC_WIDTH-1:0]        exe_bubble_pc_o,
  output logic [`BP_CTR_WIDTH-1:0]       stat_count_o,
  output logic [`BP_PC_WIDTH-1:0]        stat_last_pc_o
);

  logic [`BP_REG_ELS-1:0] pending_remote_load;
  logic [`BP_REG_ELS-1:0] pending_idiv;

  bubble_prof_pkg::bubble_type_e exe_bubble_type;
  logic [`BP_PC_WIDTH-1:0]       exe_bubble_pc;

  logic [`BP_NUM_TYPES-1:0][`BP_CTR_WIDTH-1:0] counts;
  logic [`BP_NUM_TYPES-1:0][`BP_PC_WIDTH-1:0]  last_pcs;

  scoreboard_tracker sb_tracker (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .set_i                 (sb_set_i),
    .set_id_i              (sb_set_id_i),
    .set_kind_i            (sb_set_kind_i),
    .clear_i               (sb_clear_i),
    .clear_id_i            (sb_clear_id_i),
    .pending_remote_load_o (pending_remote_load),
    .pending_idiv_o        (pending_idiv)
  );

  exe_bubble_classifier classifier (
    .clk_i, .reset_i, .if_pc_i, .id_pc_i, .exe_pc_i,
    .stall_all_i, .branch_mispredict_i, .jalr_mispredict_i,
    .icache_miss_i, .icache_miss_in_pipe_i,
    .stall_depend_long_op_i, .stall_bypass_i, .stall_fence_i, .stall_remote_req_i,
    .id_rs1_i, .id_rs2_i, .id_rd_i, .id_read_rs1_i, .id_read_rs2_i, .id_write_rd_i,
    .pending_remote_load_i (pending_remote_load),
    .pending_idiv_i        (pending_idiv),
    .exe_bubble_type_o     (exe_bubble_type),
    .exe_bubble_pc_o       (exe_bubble_pc)
  );

  assign exe_bubble_type_o = exe_bubble_type;
  assign exe_bubble_pc_o = exe_bubble_pc;

  // One counter per bubble type, indexed by the enum value.
  for (genvar i = 0; i < `BP_NUM_TYPES; i++) begin : g_counter
    bubble_counter #(.type_index_p(i)) counter (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .bubble_type_i (exe_bubble_type),
      .bubble_pc_i   (exe_bubble_pc),
      .count_o       (counts[i]),
      .last_pc_o     (last_pcs[i])
    );
  end

  bubble_stat_readout readout (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sel_i      (stat_sel_i),
    .counts_i   (counts),
    .last_pcs_i (last_pcs),
    .count_o    (stat_count_o),
    .last_pc_o  (stat_last_pc_o)
  );

endmodule

`default_nettype wire

// ==== verification/bubble_profiler_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubble_prof_macros.svh"

module bubble_profiler_tb;

  localparam int random_cycles_lp  = 2000;
  // Reset, directed tests, random phase, final readout, then margin.
  localparam int timeout_cycles_lp = 5 + 80 + random_cycles_lp + 40 + 200;

  logic clk_i;
  logic reset_i;
  logic [`BP_PC_WIDTH-1:0] if_pc_i, id_pc_i, exe_pc_i;
  logic stall_all_i, branch_mispredict_i, jalr_mispredict_i;
  logic icache_miss_i, icache_miss_in_pipe_i;
  logic stall_depend_long_op_i, stall_bypass_i, stall_fence_i, stall_remote_req_i;
  logic [`BP_REG_ADDR_WIDTH-1:0] id_rs1_i, id_rs2_i, id_rd_i, sb_set_id_i, sb_clear_id_i;
  logic id_read_rs1_i, id_read_rs2_i, id_write_rd_i, sb_set_i, sb_clear_i;
  bubble_prof_pkg::sb_kind_e sb_set_kind_i;
  logic [`BP_SEL_WIDTH-1:0] stat_sel_i;
  bubble_prof_pkg::bubble_type_e exe_bubble_type_o;
  logic [`BP_PC_WIDTH-1:0] exe_bubble_pc_o, stat_last_pc_o;
  logic [`BP_CTR_WIDTH-1:0] stat_count_o;

  // Reference model state.
  bubble_prof_pkg::bubble_type_e m_exe_type, m_id_type;
  logic [`BP_PC_WIDTH-1:0] m_exe_pc, m_id_pc, m_icache_pc, m_stat_pc;
  logic [`BP_CTR_WIDTH-1:0] m_stat_count;
  logic [`BP_REG_ELS-1:0] m_pend_load, m_pend_idiv;
  logic [`BP_CTR_WIDTH-1:0] m_counts [`BP_NUM_TYPES];
  logic [`BP_PC_WIDTH-1:0] m_last_pc [`BP_NUM_TYPES];
  int m_cycles = 0;
  bit m_started = 1'b0;

  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;
  // Registers the random stimulus has marked and not yet retired.
  bit [`BP_REG_ELS-1:0] stim_pending = '0;

  bubble_profiler_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  function automatic bit uses_flagged(input logic [`BP_REG_ELS-1:0] flags);
    return (id_read_rs1_i && flags[id_rs1_i]) || (id_read_rs2_i && flags[id_rs2_i])
        || (id_write_rd_i && flags[id_rd_i]);
  endfunction

  function automatic void classify_ref(
    output bubble_prof_pkg::bubble_type_e t,
    output logic [`BP_PC_WIDTH-1:0] pc
  );
    t = bubble_prof_pkg::e_no_bubble;
    pc = '0;
    if (branch_mispredict_i) begin
      t = bubble_prof_pkg::e_branch_miss;
      pc = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      t = bubble_prof_pkg::e_jalr_miss;
      pc = exe_pc_i;
    end else if (m_id_type != bubble_prof_pkg::e_no_bubble) begin
      t = m_id_type;
      pc = m_id_pc;
    end else if (stall_depend_long_op_i && uses_flagged(m_pend_load)) begin
      t = bubble_prof_pkg::e_depend_remote_load;
      pc = id_pc_i;
    end else if (stall_depend_long_op_i && uses_flagged(m_pend_idiv)) begin
      t = bubble_prof_pkg::e_depend_idiv;
      pc = id_pc_i;
    end else if (stall_bypass_i) begin
      t = bubble_prof_pkg::e_stall_bypass;
      pc = id_pc_i;
    end else if (stall_fence_i) begin
      t = bubble_prof_pkg::e_stall_fence;
      pc = id_pc_i;
    end else if (stall_remote_req_i) begin
      t = bubble_prof_pkg::e_stall_remote_req;
      pc = id_pc_i;
    end
  endfunction

  always @(posedge clk_i) begin : model
    bubble_prof_pkg::bubble_type_e nxt_type;
    logic [`BP_PC_WIDTH-1:0] nxt_pc;
    if (reset_i) begin
      m_started = 1'b1;
      m_cycles = 0;
      m_exe_type = bubble_prof_pkg::e_no_bubble;
      m_id_type = bubble_prof_pkg::e_no_bubble;
      m_exe_pc = '0;
      m_id_pc = '0;
      m_icache_pc = '0;
      m_stat_pc = '0;
      m_stat_count = '0;
      m_pend_load = '0;
      m_pend_idiv = '0;
      for (int k = 0; k < `BP_NUM_TYPES; k++) begin
        m_counts[k] = '0;
        m_last_pc[k] = '0;
      end
    end else begin
      m_cycles++;
      // Readout samples the counts from before this edge.
      m_stat_count = m_counts[stat_sel_i];
      m_stat_pc = m_last_pc[stat_sel_i];
      m_counts[int'(m_exe_type)]++;
      m_last_pc[int'(m_exe_type)] = m_exe_pc;
      if (!stall_all_i) begin
        classify_ref(nxt_type, nxt_pc);
        m_exe_type = nxt_type;
        m_exe_pc = nxt_pc;
        if (branch_mispredict_i || jalr_mispredict_i) begin
          m_id_type = branch_mispredict_i ? bubble_prof_pkg::e_branch_miss
                                          : bubble_prof_pkg::e_jalr_miss;
          m_id_pc = exe_pc_i;
        end else begin
          m_id_type = icache_miss_in_pipe_i ? bubble_prof_pkg::e_icache_miss
                                            : bubble_prof_pkg::e_no_bubble;
          m_id_pc = icache_miss_in_pipe_i ? m_icache_pc : '0;
        end
      end
      if (icache_miss_i) begin
        m_icache_pc = if_pc_i;
      end
      if (sb_clear_i) begin
        m_pend_load[sb_clear_id_i] = 1'b0;
        m_pend_idiv[sb_clear_id_i] = 1'b0;
      end
      if (sb_set_i && sb_set_id_i != 0) begin
        m_pend_load[sb_set_id_i] = (sb_set_kind_i == bubble_prof_pkg::e_sb_remote_load);
        m_pend_idiv[sb_set_id_i] = (sb_set_kind_i == bubble_prof_pkg::e_sb_idiv);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      error_count++;
    end
  endtask

  always @(negedge clk_i) begin : compare
    if (m_started) begin
      check_value("exe bubble type", exe_bubble_type_o, m_exe_type);
      check_value("exe bubble pc", exe_bubble_pc_o, m_exe_pc);
      check_value("readout count", stat_count_o, m_stat_count);
      check_value("readout last pc", stat_last_pc_o, m_stat_pc);
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count > timeout_cycles_lp) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  task automatic drive_idle();
    if_pc_i <= '0;
    id_pc_i <= '0;
    exe_pc_i <= '0;
    stall_all_i <= 1'b0;
    branch_mispredict_i <= 1'b0;
    jalr_mispredict_i <= 1'b0;
    icache_miss_i <= 1'b0;
    icache_miss_in_pipe_i <= 1'b0;
    stall_depend_long_op_i <= 1'b0;
    stall_bypass_i <= 1'b0;
    stall_fence_i <= 1'b0;
    stall_remote_req_i <= 1'b0;
    id_rs1_i <= '0;
    id_rs2_i <= '0;
    id_rd_i <= '0;
    id_read_rs1_i <= 1'b0;
    id_read_rs2_i <= 1'b0;
    id_write_rd_i <= 1'b0;
    sb_set_i <= 1'b0;
    sb_set_id_i <= '0;
    sb_set_kind_i <= bubble_prof_pkg::e_sb_remote_load;
    sb_clear_i <= 1'b0;
    sb_clear_id_i <= '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      drive_idle();
    end
  endtask

  task automatic read_stat(input int sel, output logic [31:0] count, output logic [31:0] pc);
    @(posedge clk_i);
    stat_sel_i <= sel[`BP_SEL_WIDTH-1:0];
    @(posedge clk_i);
    @(negedge clk_i);
    count = stat_count_o;
    pc = stat_last_pc_o;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%-22s %s (%0d errors)", name,
             (error_count == errors_before) ? "passed" : "failed",
             error_count - errors_before);
  endtask

  task automatic expect_exe(input bubble_prof_pkg::bubble_type_e t, input logic [31:0] pc);
    check_value("directed exe type", exe_bubble_type_o, t);
    check_value("directed exe pc", exe_bubble_pc_o, pc);
  endtask

  task automatic check_mispredict(input bit is_jalr, input logic [31:0] pc);
    @(posedge clk_i);
    branch_mispredict_i <= !is_jalr;
    jalr_mispredict_i <= is_jalr;
    exe_pc_i <= pc;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    expect_exe(is_jalr ? bubble_prof_pkg::e_jalr_miss : bubble_prof_pkg::e_branch_miss, pc);
    // Second sighting comes from the ID bubble register.
    @(negedge clk_i);
    expect_exe(is_jalr ? bubble_prof_pkg::e_jalr_miss : bubble_prof_pkg::e_branch_miss, pc);
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_no_bubble, '0);
  endtask

  task automatic check_dependence(input int r, input bubble_prof_pkg::sb_kind_e kind);
    @(posedge clk_i);
    sb_set_i <= 1'b1;
    sb_set_id_i <= r[`BP_REG_ADDR_WIDTH-1:0];
    sb_set_kind_i <= kind;
    @(posedge clk_i);
    sb_set_i <= 1'b0;
    stall_depend_long_op_i <= 1'b1;
    stall_bypass_i <= 1'b1;
    id_pc_i <= 32'h0000_3000 + r * 4;
    id_rd_i <= r[`BP_REG_ADDR_WIDTH-1:0];
    id_write_rd_i <= (kind == bubble_prof_pkg::e_sb_idiv);
    id_rs1_i <= r[`BP_REG_ADDR_WIDTH-1:0];
    id_read_rs1_i <= (kind == bubble_prof_pkg::e_sb_remote_load);
    @(posedge clk_i);
    sb_clear_i <= 1'b1;
    sb_clear_id_i <= r[`BP_REG_ADDR_WIDTH-1:0];
    @(negedge clk_i);
    expect_exe((kind == bubble_prof_pkg::e_sb_idiv) ? bubble_prof_pkg::e_depend_idiv
                                                    : bubble_prof_pkg::e_depend_remote_load,
               32'h0000_3000 + r * 4);
    @(posedge clk_i);
    sb_clear_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_stall_bypass, 32'h0000_3000 + r * 4);
    idle_cycles(1);
  endtask

  task automatic drive_random();
    int set_reg;
    int start;
    int cand;
    bit cleared;
    int roll;
    roll = $urandom_range(0, 99);
    branch_mispredict_i <= (roll < 4);
    jalr_mispredict_i <= (roll >= 4) && (roll < 7);
    exe_pc_i <= $urandom() & 32'hffff_fffc;
    id_pc_i <= $urandom() & 32'hffff_fffc;
    if_pc_i <= $urandom() & 32'hffff_fffc;
    icache_miss_i <= ($urandom_range(0, 99) < 5);
    icache_miss_in_pipe_i <= ($urandom_range(0, 99) < 6);
    stall_all_i <= ($urandom_range(0, 99) < 5);
    stall_depend_long_op_i <= ($urandom_range(0, 99) < 25);
    stall_bypass_i <= ($urandom_range(0, 99) < 10);
    stall_fence_i <= ($urandom_range(0, 99) < 5);
    stall_remote_req_i <= ($urandom_range(0, 99) < 5);
    id_rs1_i <= $urandom_range(0, 7);
    id_rs2_i <= $urandom_range(0, 7);
    id_rd_i <= $urandom_range(0, 7);
    id_read_rs1_i <= $urandom_range(0, 1);
    id_read_rs2_i <= $urandom_range(0, 1);
    id_write_rd_i <= $urandom_range(0, 1);
    stat_sel_i <= $urandom_range(0, `BP_NUM_TYPES - 1);
    set_reg = -1;
    sb_set_i <= 1'b0;
    if ($urandom_range(0, 99) < 15) begin
      set_reg = $urandom_range(0, 7);
      sb_set_i <= 1'b1;
      sb_set_id_i <= set_reg[`BP_REG_ADDR_WIDTH-1:0];
      sb_set_kind_i <= bubble_prof_pkg::sb_kind_e'($urandom_range(0, 1));
      if (set_reg != 0) begin
        stim_pending[set_reg] = 1'b1;
      end
    end
    // Retire only a marked register, and never the one being set now.
    cleared = 1'b0;
    sb_clear_i <= 1'b0;
    if ($urandom_range(0, 99) < 15) begin
      start = $urandom_range(0, 6);
      for (int i = 0; i < 7; i++) begin
        cand = 1 + (start + i) % 7;
        if (!cleared && stim_pending[cand] && cand != set_reg) begin
          cleared = 1'b1;
          sb_clear_i <= 1'b1;
          sb_clear_id_i <= cand[`BP_REG_ADDR_WIDTH-1:0];
          stim_pending[cand] = 1'b0;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin : stimulus
    logic [31:0] cnt;
    logic [31:0] pc;
    logic [31:0] sum;
    int errs;
    void'($urandom(68543));
    reset_i <= 1'b1;
    stat_sel_i <= '0;
    drive_idle();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    errs = error_count;
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_no_bubble, '0);
    check_value("readout count after reset", stat_count_o, '0);
    @(negedge clk_i);
    check_value("type 0 count right after reset", stat_count_o, '0);
    for (int k = 1; k < `BP_NUM_TYPES; k++) begin
      read_stat(k, cnt, pc);
      check_value("count after reset", cnt, '0);
    end
    report_test("reset state", errs);

    errs = error_count;
    check_mispredict(1'b0, 32'h0000_1004);
    check_mispredict(1'b1, 32'h0000_1108);
    report_test("mispredictions", errs);

    errs = error_count;
    @(posedge clk_i);
    icache_miss_i <= 1'b1;
    if_pc_i <= 32'h0000_2040;
    @(posedge clk_i);
    icache_miss_i <= 1'b0;
    if_pc_i <= 32'h0000_2044;
    icache_miss_in_pipe_i <= 1'b1;
    @(posedge clk_i);
    icache_miss_in_pipe_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_icache_miss, 32'h0000_2040);
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_no_bubble, '0);
    report_test("icache miss", errs);

    errs = error_count;
    check_dependence(5, bubble_prof_pkg::e_sb_remote_load);
    check_dependence(9, bubble_prof_pkg::e_sb_idiv);
    report_test("scoreboard dependence", errs);

    errs = error_count;
    @(posedge clk_i);
    stall_fence_i <= 1'b1;
    id_pc_i <= 32'h0000_4010;
    @(posedge clk_i);
    stall_all_i <= 1'b1;
    stall_fence_i <= 1'b0;
    stall_remote_req_i <= 1'b1;
    id_pc_i <= 32'h0000_4020;
    repeat (4) begin
      @(negedge clk_i);
      expect_exe(bubble_prof_pkg::e_stall_fence, 32'h0000_4010);
    end
    @(posedge clk_i);
    stall_all_i <= 1'b0;
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_stall_fence, 32'h0000_4010);
    @(negedge clk_i);
    expect_exe(bubble_prof_pkg::e_stall_remote_req, 32'h0000_4020);
    idle_cycles(1);
    report_test("stall hold", errs);

    errs = error_count;
    repeat (random_cycles_lp) begin
      @(posedge clk_i);
      drive_random();
    end
    // Let EXE drain so only the idle counter keeps moving.
    idle_cycles(3);
    sum = '0;
    for (int k = 1; k < `BP_NUM_TYPES; k++) begin
      read_stat(k, cnt, pc);
      check_value("final count", cnt, m_counts[k]);
      check_value("final last pc", pc, m_last_pc[k]);
      sum = sum + cnt;
    end
    read_stat(0, cnt, pc);
    check_value("final idle count", cnt, m_counts[0] - 1);
    sum = sum + cnt;
    check_value("sum of all counts", sum, m_cycles - 1);
    report_test("random and readout", errs);

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/bubble_prof_pkg.sv
design/scoreboard_tracker.sv
bubble_classifier/exe_bubble_classifier.sv
design/bubble_counter.sv
design/bubble_stat_readout.sv
design/bubble_profiler_top.sv
verification/bubble_profiler_tb.sv
